/* design/kalman_settings.svh */
/*
  Build-time constants of the 2D constant-gain Kalman tracker.
  Fixed point is signed two's complement, KF_ARCH_F fraction bits.
  Default gains and the time step are the values loaded at reset.
*/
`ifndef KALMAN_SETTINGS_SVH
`define KALMAN_SETTINGS_SVH

// Datapath format
`define KF_ARCH_W       36
`define KF_ARCH_F       15
`define KF_DISP_W       11

// State space size, states are x, y, vx, vy
`define KF_NUM_STATES   4
`define KF_NUM_MEASUR   2

`define KF_CFG_ADDR_W   4

// Defaults: 0.5, 0.125, 2^-5 and 1.0 in fixed point
`define KF_GAIN_POS_DEF (36'sd1 <<< (`KF_ARCH_F - 1))
`define KF_GAIN_VEL_DEF (36'sd1 <<< (`KF_ARCH_F - 3))
`define KF_TSTEP_DEF    (36'sd1 <<< (`KF_ARCH_F - 5))
`define KF_X_INIT       (36'sd1 <<< `KF_ARCH_F)

`endif

/* design/kalman_pkg.sv */
/*
  Shared types of the Kalman tracker and the fixed-point multiply.
  fx_mul truncates toward minus infinity and wraps, it never saturates.
*/
`default_nettype none

`include "kalman_settings.svh"

package kalman_pkg;

	// Signed fixed-point word
	typedef logic signed [`KF_ARCH_W-1:0] fx_t;

	// Integer display coordinate
	typedef logic [`KF_DISP_W-1:0] disp_t;

	typedef logic [`KF_CFG_ADDR_W-1:0] cfg_addr_t;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE,
		PREDICT,
		INNOVATE,
		UPDATE
	} kf_state_e;

	// Full product, drop the fraction bits, wrap to the word width
	function automatic fx_t fx_mul(input fx_t a, input fx_t b);
		logic signed [2*`KF_ARCH_W-1:0] prod;
		prod = a * b;
		return fx_t'(prod >>> `KF_ARCH_F);
	endfunction

endpackage

`default_nettype wire

/* design/kalman_ctrl.sv */
/*
  Sequencer of one filter iteration: IDLE, PREDICT, INNOVATE, UPDATE.
  A sample is taken when i_valid is high while idle. Busy lasts three cycles.
*/
`timescale 1ns/10ps
`default_nettype none

module kalman_ctrl (
	input  logic clk,
	input  logic aresetn,
	input  logic i_valid,
	output logic o_ready,
	output logic o_busy,
	output logic o_accept,
	output logic o_predict,
	output logic o_innovate,
	output logic o_update
);
	import kalman_pkg::*;

	kf_state_e state_q;
	kf_state_e state_d;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Fixed walk through the phases once a sample is in
	always_comb begin
		case (state_q)
			IDLE:     state_d = i_valid ? PREDICT : IDLE;
			PREDICT:  state_d = INNOVATE;
			INNOVATE: state_d = UPDATE;
			UPDATE:   state_d = IDLE;
			default:  state_d = IDLE;
		endcase
	end

	assign o_ready    = (state_q == IDLE);
	assign o_busy     = ~o_ready;
	assign o_accept   = o_ready & i_valid;
	assign o_predict  = (state_q == PREDICT);
	assign o_innovate = (state_q == INNOVATE);
	assign o_update   = (state_q == UPDATE);

	////////////////////
	// Checks

	a_one_strobe: assert property (@(posedge clk) disable iff (!aresetn)
		(state_q != IDLE) |-> $onehot({o_predict, o_innovate, o_update}));

endmodule

`default_nettype wire

/* design/kalman_gain_regs.sv */
/*
  Programmable gain matrix K (4x2) and time step.
  Address r*2+c is K[r][c], address 8 the time step, 9 to 15 unused.
  Writes are taken only while the filter is idle.
*/
`timescale 1ns/10ps
`default_nettype none

`include "kalman_settings.svh"

module kalman_gain_regs (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic                  i_busy,
	input  logic                  i_cfg_we,
	input  kalman_pkg::cfg_addr_t i_cfg_addr,
	input  kalman_pkg::fx_t       i_cfg_data,
	output kalman_pkg::fx_t       o_gain [`KF_NUM_STATES][`KF_NUM_MEASUR],
	output kalman_pkg::fx_t       o_tstep
);
	import kalman_pkg::*;

	localparam int        NUM_GAINS  = `KF_NUM_STATES * `KF_NUM_MEASUR;
	localparam cfg_addr_t TSTEP_ADDR = cfg_addr_t'(NUM_GAINS);

	logic wr_en;

	// Busy drops the write entirely, nothing is queued
	assign wr_en = i_cfg_we & ~i_busy;

	////////////////////
	// Gain words

	for (genvar r = 0; r < `KF_NUM_STATES; r++) begin : g_row
		for (genvar c = 0; c < `KF_NUM_MEASUR; c++) begin : g_col
			localparam cfg_addr_t ADDR = cfg_addr_t'(r * `KF_NUM_MEASUR + c);
			// Position rows see their own axis, velocity rows the matching axis
			localparam fx_t DEF =
				(r == c)                  ? fx_t'(`KF_GAIN_POS_DEF) :
				(r == c + `KF_NUM_MEASUR) ? fx_t'(`KF_GAIN_VEL_DEF) :
				                            fx_t'(0);

			always_ff @(posedge clk or negedge aresetn) begin
				if (!aresetn) begin
					o_gain[r][c] <= DEF;
				end else if (wr_en && i_cfg_addr == ADDR) begin
					o_gain[r][c] <= i_cfg_data;
				end
			end

			a_gain_hold: assert property (@(posedge clk) disable iff (!aresetn)
				i_busy |=> $stable(o_gain[r][c]));
		end
	end

	////////////////////
	// Time step

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			o_tstep <= fx_t'(`KF_TSTEP_DEF);
		end else if (wr_en && i_cfg_addr == TSTEP_ADDR) begin
			o_tstep <= i_cfg_data;
		end
	end

	a_tstep_hold: assert property (@(posedge clk) disable iff (!aresetn)
		i_busy |=> $stable(o_tstep));

endmodule

`default_nettype wire

/* design/kalman_predict.sv */
/*
  State propagation x_next = F*x for a constant-velocity model.
  F is fixed in structure, only the time step is programmable.
  States 0..1 are positions, 2..3 the matching velocities.
*/
`timescale 1ns/10ps
`default_nettype none

`include "kalman_settings.svh"

module kalman_predict (
	input  logic            clk,
	input  logic            aresetn,
	input  logic            i_predict,
	input  kalman_pkg::fx_t i_tstep,
	input  kalman_pkg::fx_t i_x_curr [`KF_NUM_STATES],
	output kalman_pkg::fx_t o_x_next [`KF_NUM_STATES]
);
	import kalman_pkg::*;

	localparam int NUM_POS = `KF_NUM_STATES / 2;

	fx_t x_pred [`KF_NUM_STATES];

	// Rows of F: identity plus the time step coupling velocity into position
	for (genvar i = 0; i < `KF_NUM_STATES; i++) begin : g_state
		if (i < NUM_POS) begin : g_pos
			assign x_pred[i] = i_x_curr[i] + fx_mul(i_tstep, i_x_curr[i + NUM_POS]);
		end else begin : g_vel
			// Velocity carries over unchanged
			assign x_pred[i] = i_x_curr[i];
		end
	end

	// Prediction register, loaded once per sample
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < `KF_NUM_STATES; i++) begin
				o_x_next[i] <= fx_t'(`KF_X_INIT);
			end
		end else if (i_predict) begin
			for (int i = 0; i < `KF_NUM_STATES; i++) begin
				o_x_next[i] <= x_pred[i];
			end
		end
	end

endmodule

`default_nettype wire

/* design/kalman_correct.sv */
/*
  Measurement latch, innovation and gain correction x = x_next + K*y.
  Measurements are integers, the display shows the integer part of x and y.
  Integer parts wrap beyond KF_DISP_W bits.
*/
`timescale 1ns/10ps
`default_nettype none

`include "kalman_settings.svh"

module kalman_correct (
	input  logic              clk,
	input  logic              aresetn,
	input  logic              i_accept,
	input  logic              i_innovate,
	input  logic              i_update,
	input  kalman_pkg::disp_t i_z_x,
	input  kalman_pkg::disp_t i_z_y,
	input  kalman_pkg::fx_t   i_x_next [`KF_NUM_STATES],
	input  kalman_pkg::fx_t   i_gain [`KF_NUM_STATES][`KF_NUM_MEASUR],
	output kalman_pkg::fx_t   o_x_curr [`KF_NUM_STATES],
	output kalman_pkg::disp_t o_z_x_new,
	output kalman_pkg::disp_t o_z_y_new
);
	import kalman_pkg::*;

	fx_t z_q   [`KF_NUM_MEASUR];
	fx_t y_q   [`KF_NUM_MEASUR];
	fx_t x_upd [`KF_NUM_STATES];
	fx_t x_q   [`KF_NUM_STATES];

	////////////////////
	// Measurement and innovation

	// Whole units, fraction bits zero
	always_ff @(posedge clk) begin
		if (i_accept) begin
			z_q[0] <= fx_t'(i_z_x) <<< `KF_ARCH_F;
			z_q[1] <= fx_t'(i_z_y) <<< `KF_ARCH_F;
		end
	end

	// H only picks the position states, so no multiply here
	always_ff @(posedge clk) begin
		if (i_innovate) begin
			for (int c = 0; c < `KF_NUM_MEASUR; c++) begin
				y_q[c] <= z_q[c] - i_x_next[c];
			end
		end
	end

	////////////////////
	// Correction

	for (genvar r = 0; r < `KF_NUM_STATES; r++) begin : g_row
		always_comb begin
			fx_t acc;
			acc = i_x_next[r];
			for (int c = 0; c < `KF_NUM_MEASUR; c++) begin
				acc = acc + fx_mul(i_gain[r][c], y_q[c]);
			end
			x_upd[r] = acc;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int r = 0; r < `KF_NUM_STATES; r++) begin
				x_q[r] <= fx_t'(`KF_X_INIT);
			end
		end else if (i_update) begin
			for (int r = 0; r < `KF_NUM_STATES; r++) begin
				x_q[r] <= x_upd[r];
			end
		end
	end

	assign o_x_curr = x_q;

	// Integer part of the two positions
	assign o_z_x_new = x_q[0][`KF_ARCH_F +: `KF_DISP_W];
	assign o_z_y_new = x_q[1][`KF_ARCH_F +: `KF_DISP_W];

endmodule

`default_nettype wire

/* design/kalman_top.sv */
/*
  Constant-gain Kalman position tracker, top level.
  One sample in flight, o_ready low for three cycles per sample.
  Gain and time step writes are dropped while o_ready is low.
*/
`timescale 1ns/10ps
`default_nettype none

`include "kalman_settings.svh"

module kalman_top (
	input  logic                  clk,
	input  logic                  aresetn,

	// Measurement side
	input  kalman_pkg::disp_t     i_z_x,
	input  kalman_pkg::disp_t     i_z_y,
	input  logic                  i_valid,
	output logic                  o_ready,

	// Configuration writes
	input  logic                  i_cfg_we,
	input  kalman_pkg::cfg_addr_t i_cfg_addr,
	input  kalman_pkg::fx_t       i_cfg_data,

	// Estimate
	output kalman_pkg::disp_t     o_z_x_new,
	output kalman_pkg::disp_t     o_z_y_new
);
	import kalman_pkg::*;

	logic busy;
	logic accept;
	logic predict;
	logic innovate;
	logic update;

	fx_t  gain   [`KF_NUM_STATES][`KF_NUM_MEASUR];
	fx_t  tstep;
	fx_t  x_curr [`KF_NUM_STATES];
	fx_t  x_next [`KF_NUM_STATES];

	kalman_ctrl u_ctrl (
		.clk        (clk),
		.aresetn    (aresetn),
		.i_valid    (i_valid),
		.o_ready    (o_ready),
		.o_busy     (busy),
		.o_accept   (accept),
		.o_predict  (predict),
		.o_innovate (innovate),
		.o_update   (update)
	);

	kalman_gain_regs u_gain_regs (
		.clk        (clk),
		.aresetn    (aresetn),
		.i_busy     (busy),
		.i_cfg_we   (i_cfg_we),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_data (i_cfg_data),
		.o_gain     (gain),
		.o_tstep    (tstep)
	);

	kalman_predict u_predict (
		.clk       (clk),
		.aresetn   (aresetn),
		.i_predict (predict),
		.i_tstep   (tstep),
		.i_x_curr  (x_curr),
		.o_x_next  (x_next)
	);

	kalman_correct u_correct (
		.clk        (clk),
		.aresetn    (aresetn),
		.i_accept   (accept),
		.i_innovate (innovate),
		.i_update   (update),
		.i_z_x      (i_z_x),
		.i_z_y      (i_z_y),
		.i_x_next   (x_next),
		.i_gain     (gain),
		.o_x_curr   (x_curr),
		.o_z_x_new  (o_z_x_new),
		.o_z_y_new  (o_z_y_new)
	);

endmodule

`default_nettype wire

/* dv/kalman_tb.sv */
/*
  Directed testbench of kalman_top with a fixed-point reference model.
  Inputs change on the falling clock edge and outputs are sampled there too.
  The model follows the truncating multiply and wrap of the datapath.
*/
`timescale 1ns/10ps
`default_nettype none

`include "kalman_settings.svh"

module kalman_tb;
	import kalman_pkg::*;

	// 20 default, 8 + 6 full gain, 10 ramp, 5 busy
	localparam int  NUM_SAMPLES     = 49;
	localparam int  WATCHDOG_CYCLES = NUM_SAMPLES * 10 + 200;
	localparam int  READY_LIMIT     = 10;
	localparam fx_t ONE             = fx_t'(1) <<< `KF_ARCH_F;
	localparam fx_t POS_DEF         = ONE >>> 1;
	localparam fx_t VEL_DEF         = ONE >>> 3;
	localparam fx_t TSTEP_DEF       = ONE >>> 5;

	logic      clk;
	logic      aresetn;
	disp_t     i_z_x;
	disp_t     i_z_y;
	logic      i_valid;
	logic      o_ready;
	logic      i_cfg_we;
	cfg_addr_t i_cfg_addr;
	fx_t       i_cfg_data;
	disp_t     o_z_x_new;
	disp_t     o_z_y_new;

	int mismatch_count;
	int fail_count;

	// Reference model state
	fx_t m_x    [`KF_NUM_STATES];
	fx_t m_gain [`KF_NUM_STATES][`KF_NUM_MEASUR];
	fx_t m_tstep;

	kalman_top i_kalman_top (
		.clk        (clk),
		.aresetn    (aresetn),
		.i_z_x      (i_z_x),
		.i_z_y      (i_z_y),
		.i_valid    (i_valid),
		.o_ready    (o_ready),
		.i_cfg_we   (i_cfg_we),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_data (i_cfg_data),
		.o_z_x_new  (o_z_x_new),
		.o_z_y_new  (o_z_y_new)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	////////////////////
	// Reference model

	function automatic fx_t ref_mul(input fx_t a, input fx_t b);
		logic [2*`KF_ARCH_W-1:0] full;
		// Low half of the product of sign-extended operands is the signed product
		full = {{`KF_ARCH_W{a[`KF_ARCH_W-1]}}, a} * {{`KF_ARCH_W{b[`KF_ARCH_W-1]}}, b};
		return fx_t'(full[`KF_ARCH_F +: `KF_ARCH_W]);
	endfunction

	function automatic void model_reset();
		for (int r = 0; r < `KF_NUM_STATES; r++) begin
			m_x[r] = ONE;
			for (int c = 0; c < `KF_NUM_MEASUR; c++) begin
				m_gain[r][c] = fx_t'(0);
			end
		end
		m_gain[0][0] = POS_DEF;
		m_gain[1][1] = POS_DEF;
		m_gain[2][0] = VEL_DEF;
		m_gain[3][1] = VEL_DEF;
		m_tstep      = TSTEP_DEF;
	endfunction

	// Address r*2+c is K[r][c] and address 8 the time step
	function automatic void model_write(input int addr, input fx_t data);
		if (addr < `KF_NUM_STATES * `KF_NUM_MEASUR) begin
			m_gain[addr / `KF_NUM_MEASUR][addr % `KF_NUM_MEASUR] = data;
		end else if (addr == `KF_NUM_STATES * `KF_NUM_MEASUR) begin
			m_tstep = data;
		end
	endfunction

	function automatic void model_step(input disp_t zx, input disp_t zy);
		fx_t xn   [`KF_NUM_STATES];
		fx_t z    [`KF_NUM_MEASUR];
		fx_t inov [`KF_NUM_MEASUR];
		fx_t acc;
		z[0] = fx_t'({zx, {`KF_ARCH_F{1'b0}}});
		z[1] = fx_t'({zy, {`KF_ARCH_F{1'b0}}});
		for (int i = 0; i < `KF_NUM_MEASUR; i++) begin
			xn[i]     = m_x[i] + ref_mul(m_tstep, m_x[i + 2]);
			xn[i + 2] = m_x[i + 2];
			inov[i]   = z[i] - xn[i];
		end
		for (int r = 0; r < `KF_NUM_STATES; r++) begin
			acc = xn[r];
			for (int c = 0; c < `KF_NUM_MEASUR; c++) begin
				acc = acc + ref_mul(m_gain[r][c], inov[c]);
			end
			m_x[r] = acc;
		end
	endfunction

	////////////////////
	// Drivers

	task automatic write_cfg(input int addr, input fx_t data);
		@(negedge clk);
		i_cfg_we   = 1'b1;
		i_cfg_addr = cfg_addr_t'(addr);
		i_cfg_data = data;
		@(negedge clk);
		i_cfg_we = 1'b0;
		model_write(addr, data);
	endtask

	// Position gains on the diagonal and velocity gains on the matching axis
	task automatic write_gains(input fx_t pos, input fx_t vel);
		fx_t val;
		for (int a = 0; a < `KF_NUM_STATES * `KF_NUM_MEASUR; a++) begin
			val = (a == 0 || a == 3) ? pos : (a == 4 || a == 7) ? vel : fx_t'(0);
			write_cfg(a, val);
		end
	endtask

	// One sample with optional new data and a gain write while busy
	task automatic run_sample(input disp_t zx, input disp_t zy, input bit inject);
		int low_cycles;
		@(negedge clk);
		if (!o_ready) begin
			$display("DUT was not ready when a sample was due at %0t ns", $time);
			fail_count++;
		end
		i_z_x   = zx;
		i_z_y   = zy;
		i_valid = 1'b1;
		@(negedge clk);
		if (inject) begin
			i_z_x      = ~zx;
			i_z_y      = ~zy;
			i_cfg_we   = 1'b1;
			i_cfg_addr = cfg_addr_t'(0);
			i_cfg_data = ONE;
		end else begin
			i_valid = 1'b0;
		end
		low_cycles = 0;
		while (!o_ready && low_cycles < READY_LIMIT) begin
			low_cycles++;
			@(negedge clk);
			i_valid  = 1'b0;
			i_cfg_we = 1'b0;
		end
		if (!o_ready) begin
			$display("o_ready stayed low after a sample at %0t ns", $time);
			fail_count++;
		end else if (low_cycles != 3) begin
			$display("MISMATCH at %0t ns: o_ready low for %0d cycles, expected 3",
				$time, low_cycles);
			mismatch_count++;
		end
		model_step(zx, zy);
		if (o_z_x_new !== m_x[0][`KF_ARCH_F +: `KF_DISP_W]) begin
			$display("MISMATCH at %0t ns: o_z_x_new %0d, expected %0d",
				$time, o_z_x_new, m_x[0][`KF_ARCH_F +: `KF_DISP_W]);
			mismatch_count++;
		end
		if (o_z_y_new !== m_x[1][`KF_ARCH_F +: `KF_DISP_W]) begin
			$display("MISMATCH at %0t ns: o_z_y_new %0d, expected %0d",
				$time, o_z_y_new, m_x[1][`KF_ARCH_F +: `KF_DISP_W]);
			mismatch_count++;
		end
	endtask

	////////////////////
	// Tests

	task automatic test_after_reset();
		@(negedge clk);
		if (o_ready !== 1'b1) begin
			$display("MISMATCH at %0t ns: o_ready %b after reset", $time, o_ready);
			mismatch_count++;
		end
		if (o_z_x_new !== disp_t'(1) || o_z_y_new !== disp_t'(1)) begin
			$display("MISMATCH at %0t ns: outputs %0d,%0d after reset, expected 1,1",
				$time, o_z_x_new, o_z_y_new);
			mismatch_count++;
		end
	endtask

	task automatic test_default_gains();
		for (int k = 0; k < 20; k++) begin
			run_sample(disp_t'($urandom % 2048), disp_t'($urandom % 2048), 1'b0);
		end
	endtask

	task automatic test_full_position_gain();
		disp_t zx;
		disp_t zy;
		write_gains(ONE, fx_t'(0));
		for (int k = 0; k < 8; k++) begin
			zx = disp_t'($urandom % 2048);
			zy = disp_t'($urandom % 2048);
			run_sample(zx, zy, 1'b0);
			// Unit gain puts the estimate on the measurement
			if (o_z_x_new !== zx || o_z_y_new !== zy) begin
				$display("MISMATCH at %0t ns: estimate %0d,%0d, measurement %0d,%0d",
					$time, o_z_x_new, o_z_y_new, zx, zy);
				mismatch_count++;
			end
		end
		write_gains(POS_DEF, VEL_DEF);
		write_cfg(8, TSTEP_DEF);
		for (int k = 0; k < 6; k++) begin
			run_sample(disp_t'($urandom % 2048), disp_t'($urandom % 2048), 1'b0);
		end
	endtask

	task automatic test_time_step();
		write_cfg(8, ONE >>> 3);
		write_cfg(4, ONE >>> 2);
		write_cfg(7, ONE >>> 2);
		// Constant-velocity ramp
		for (int k = 0; k < 10; k++) begin
			run_sample(disp_t'(100 + 4 * k), disp_t'(50 + 2 * k), 1'b0);
		end
	endtask

	task automatic test_busy_behavior();
		run_sample(disp_t'(300), disp_t'(400), 1'b1);
		for (int k = 0; k < 2; k++) begin
			run_sample(disp_t'($urandom % 2048), disp_t'($urandom % 2048), 1'b0);
		end
		write_cfg(12, ONE);
		for (int k = 0; k < 2; k++) begin
			run_sample(disp_t'($urandom % 2048), disp_t'($urandom % 2048), 1'b0);
		end
	endtask

	initial begin
		void'($urandom(32'h6a9a));
		aresetn        = 1'b0;
		i_z_x          = '0;
		i_z_y          = '0;
		i_valid        = 1'b0;
		i_cfg_we       = 1'b0;
		i_cfg_addr     = '0;
		i_cfg_data     = '0;
		mismatch_count = 0;
		fail_count     = 0;
		model_reset();
		repeat (16) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;

		test_after_reset();
		test_default_gains();
		test_full_position_gain();
		test_time_step();
		test_busy_behavior();

		$display("Done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/kalman_pkg.sv
design/kalman_ctrl.sv
design/kalman_gain_regs.sv
design/kalman_predict.sv
design/kalman_correct.sv
design/kalman_top.sv
dv/kalman_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the Kalman tracker testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module kalman_tb \
	-Mdir "$BUILD_DIR" -o kalman_sim \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/kalman_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Regression failed" "$LOG_FILE"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG_FILE"; then
	echo "No result line found in $LOG_FILE"
	exit 1
fi
exit 0
